/* logic/target_settings.svh */
// target tracker settings: frame geometry, zone split and orange colour limits
`ifndef TARGET_SETTINGS_SVH
`define TARGET_SETTINGS_SVH

// active pixels per line
// the column counter wraps here
`define FRAME_WIDTH 320

// vertical column bands across the frame
// the steering map assumes five
`define ZONE_COUNT 5

// pixels per band
`define ZONE_WIDTH (`FRAME_WIDTH / `ZONE_COUNT)

// orange window on the expanded 8-bit channels
// red floor, green window, blue ceiling
`define ORANGE_R_MIN 200
`define ORANGE_G_MIN 64
`define ORANGE_G_MAX 180
`define ORANGE_B_MAX 80

// winning zone needs at least this many orange pixels
`define DETECT_MIN 32

// zone count width
// 17 bits covers a full 320x240 frame
`define COUNT_BITS 17

`endif

/* logic/pixel_pkg.sv */
// pixel package: colour word types and the beat passed from the classifier to the zone counters
`include "target_settings.svh"

package pixel_pkg;

  // frame buffer word, 4 bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  // display word, 8 bits per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // column index inside one line
  // 9 bits for 320 pixels
  typedef logic [$clog2(`FRAME_WIDTH)-1:0] column_t;

  // one classified pixel
  // colour already expanded
  // orange bit from the colour test
  // col is the column of this pixel
  typedef struct packed {
    rgb888_t colour;
    logic    orange;
    column_t col;
  } pixel_beat_t;

endpackage

/* logic/steer_pkg.sv */
// steering package: direction enum, zone count type and the per-frame verdict
`include "target_settings.svh"

package steer_pkg;

  // steering command for the drive logic
  // dir_none when nothing orange enough was seen
  typedef enum logic [2:0] {
    dir_none       = 3'd0,
    dir_hard_left  = 3'd1,
    dir_left       = 3'd2,
    dir_ahead      = 3'd3,
    dir_right      = 3'd4,
    dir_hard_right = 3'd5
  } direction_t;

  // orange pixels counted in one zone over one frame
  typedef logic [`COUNT_BITS-1:0] zone_count_t;

  // result reported once per frame
  // count is the winning zone's count
  // it is kept even when detected is low
  typedef struct packed {
    direction_t  direction;
    logic        detected;
    zone_count_t count;
  } verdict_t;

  // verdict after reset and before the first frame ends
  localparam verdict_t VERDICT_IDLE = '{
    direction: dir_none,
    detected:  1'b0,
    count:     '0
  };

endpackage

/* logic/pixel_classifier.sv */
// pixel classifier: expands rgb444, tests for orange, marks the display pixel and tracks the column
`timescale 1ns/1ps
`include "target_settings.svh"

module pixel_classifier (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pixel_pkg::rgb444_t     pix_in,
  input  logic                   pix_active,
  input  logic                   frame_end,
  output pixel_pkg::rgb888_t     pix_out,
  output logic                   pix_out_active,
  output pixel_pkg::pixel_beat_t beat,
  output logic                   beat_valid,
  output logic                   frame_done
);

  // last active column before the wrap
  localparam pixel_pkg::column_t LAST_COL = pixel_pkg::column_t'(`FRAME_WIDTH - 1);

  pixel_pkg::rgb888_t colour;
  logic               is_orange;
  pixel_pkg::column_t col_q;

  // nibble repeated into both halves, same as nibble * 17
  always_comb begin
    colour.r = {pix_in.r, pix_in.r};
    colour.g = {pix_in.g, pix_in.g};
    colour.b = {pix_in.b, pix_in.b};
  end

  // orange window, all limits inclusive
  always_comb begin
    is_orange = (colour.r >= 8'(`ORANGE_R_MIN)) &&
                (colour.g >= 8'(`ORANGE_G_MIN)) &&
                (colour.g <= 8'(`ORANGE_G_MAX)) &&
                (colour.b <= 8'(`ORANGE_B_MAX));
  end

  // strobes and column state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_out_active <= 1'b0;
      beat_valid     <= 1'b0;
      frame_done     <= 1'b0;
      col_q          <= '0;
    end else begin
      pix_out_active <= pix_active;
      beat_valid     <= pix_active;
      frame_done     <= frame_end;
      // frame_end never shares a cycle with a pixel
      if (frame_end) begin
        col_q <= '0;
      end else if (pix_active) begin
        col_q <= (col_q == LAST_COL) ? '0 : col_q + 1'b1;
      end
    end
  end

  // display pixel and beat payload
  always_ff @(posedge clk) begin
    // black outside the active area, white on target
    if (!pix_active) begin
      pix_out <= '0;
    end else if (is_orange) begin
      pix_out <= '1;
    end else begin
      pix_out <= colour;
    end
    beat.colour <= colour;
    beat.orange <= is_orange;
    // column of this pixel, before the advance
    beat.col    <= col_q;
  end

endmodule

/* logic/zone_counter.sv */
// zone counter: counts orange pixels inside one column band over one frame
`timescale 1ns/1ps
`include "target_settings.svh"

module zone_counter #(
  parameter int ZONE_INDEX = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pixel_pkg::pixel_beat_t beat,
  input  logic                   beat_valid,
  input  logic                   frame_done,
  output steer_pkg::zone_count_t count
);

  // band edges, low inclusive and high exclusive
  // the high edge of the last band is 320, still inside 9 bits
  localparam pixel_pkg::column_t BAND_LO =
    pixel_pkg::column_t'(ZONE_INDEX * `ZONE_WIDTH);
  localparam pixel_pkg::column_t BAND_HI =
    pixel_pkg::column_t'((ZONE_INDEX + 1) * `ZONE_WIDTH);

  logic in_band;
  logic hit;
  logic at_max;

  always_comb begin
    in_band = (beat.col >= BAND_LO) && (beat.col < BAND_HI);
    hit     = beat_valid && beat.orange && in_band;
    // hold at full scale
    at_max  = (count == '1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (frame_done) begin
      // decider samples on this same edge
      count <= '0;
    end else if (hit && !at_max) begin
      count <= count + 1'b1;
    end
  end

endmodule

/* logic/steer_decider.sv */
// steer decider: picks the zone with the most orange at frame end and registers the verdict
`timescale 1ns/1ps
`include "target_settings.svh"

module steer_decider (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  steer_pkg::zone_count_t [`ZONE_COUNT-1:0]  counts,
  input  logic                                      frame_done,
  output steer_pkg::verdict_t                       verdict,
  output logic                                      verdict_valid
);

  localparam int IDX_BITS = $clog2(`ZONE_COUNT);

  logic [IDX_BITS-1:0]    best_idx;
  steer_pkg::zone_count_t best_count;
  steer_pkg::verdict_t    next_verdict;

  // running maximum
  // strict compare keeps the lower zone on a tie
  always_comb begin
    best_idx   = '0;
    best_count = counts[0];
    for (int i = 1; i < `ZONE_COUNT; i++) begin
      if (counts[i] > best_count) begin
        best_idx   = IDX_BITS'(i);
        best_count = counts[i];
      end
    end
  end

  // threshold then zone to direction
  always_comb begin
    next_verdict.count    = best_count;
    next_verdict.detected = (best_count >= steer_pkg::zone_count_t'(`DETECT_MIN));
    if (!next_verdict.detected) begin
      next_verdict.direction = steer_pkg::dir_none;
    end else begin
      // zone 0 is the left edge of the image
      case (best_idx)
        IDX_BITS'(0): next_verdict.direction = steer_pkg::dir_hard_left;
        IDX_BITS'(1): next_verdict.direction = steer_pkg::dir_left;
        IDX_BITS'(2): next_verdict.direction = steer_pkg::dir_ahead;
        IDX_BITS'(3): next_verdict.direction = steer_pkg::dir_right;
        IDX_BITS'(4): next_verdict.direction = steer_pkg::dir_hard_right;
        default:      next_verdict.direction = steer_pkg::dir_none;
      endcase
    end
  end

  // one verdict per frame, held until the next one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      verdict       <= steer_pkg::VERDICT_IDLE;
      verdict_valid <= 1'b0;
    end else begin
      verdict_valid <= frame_done;
      if (frame_done) begin
        verdict <= next_verdict;
      end
    end
  end

endmodule

/* logic/target_tracker.sv */
// target tracker top: classifier, one counter per column band and the steering decider
`timescale 1ns/1ps
`include "target_settings.svh"

module target_tracker (
  input  logic                clk,
  input  logic                rst_n,
  input  pixel_pkg::rgb444_t  pix_in,
  input  logic                pix_active,
  input  logic                frame_end,
  output pixel_pkg::rgb888_t  pix_out,
  output logic                pix_out_active,
  output steer_pkg::verdict_t verdict,
  output logic                verdict_valid
);

  // classifier to counters and decider
  pixel_pkg::pixel_beat_t beat;
  logic                   beat_valid;
  logic                   frame_done;

  // one count per band, zone 0 in the low slot
  steer_pkg::zone_count_t [`ZONE_COUNT-1:0] zone_counts;

  pixel_classifier u_classifier (
    .clk            (clk),
    .rst_n          (rst_n),
    .pix_in         (pix_in),
    .pix_active     (pix_active),
    .frame_end      (frame_end),
    .pix_out        (pix_out),
    .pix_out_active (pix_out_active),
    .beat           (beat),
    .beat_valid     (beat_valid),
    .frame_done     (frame_done)
  );

  // same beat broadcast to every band
  for (genvar z = 0; z < `ZONE_COUNT; z++) begin : g_zone
    zone_counter #(
      .ZONE_INDEX (z)
    ) u_zone (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .beat_valid (beat_valid),
      .frame_done (frame_done),
      .count      (zone_counts[z])
    );
  end

  steer_decider u_decider (
    .clk           (clk),
    .rst_n         (rst_n),
    .counts        (zone_counts),
    .frame_done    (frame_done),
    .verdict       (verdict),
    .verdict_valid (verdict_valid)
  );

endmodule

/* verif/target_tracker_sva.sv */
// tracker assertions on verdict pulse timing, display strobe latency and values held in reset
`timescale 1ns/1ps
`include "target_settings.svh"

module target_tracker_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                pix_active,
  input logic                frame_end,
  input logic                pix_out_active,
  input logic                verdict_valid,
  input steer_pkg::verdict_t verdict
);

  int fail_count = 0;

  // verdict two edges after frame_end
  a_valid_after_end: assert property (@(posedge clk) disable iff (!rst_n)
    frame_end |-> ##2 verdict_valid)
    else begin
      fail_count++;
      $error("verdict_valid missing two cycles after frame_end");
    end

  a_valid_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
    verdict_valid |-> $past(frame_end, 2))
    else begin
      fail_count++;
      $error("verdict_valid without frame_end two cycles before");
    end

  a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    verdict_valid |=> !verdict_valid)
    else begin
      fail_count++;
      $error("verdict_valid high for more than one cycle");
    end

  a_active_latency: assert property (@(posedge clk) disable iff (!rst_n)
    pix_out_active == $past(pix_active))
    else begin
      fail_count++;
      $error("pix_out_active does not follow pix_active by one cycle");
    end

  // held in reset for a full cycle
  a_reset_values: assert property (@(posedge clk)
    (!rst_n && $past(rst_n) === 1'b0) |->
      (!pix_out_active && !verdict_valid && verdict == steer_pkg::VERDICT_IDLE))
    else begin
      fail_count++;
      $error("outputs not idle while rst_n is low");
    end

endmodule

bind target_tracker target_tracker_sva u_sva (.*);

/* verif/target_tracker_checker.sv */
// tracker checker: recomputes display pixels and zone totals from the inputs and compares the dut
`timescale 1ns/1ps
`include "target_settings.svh"

module target_tracker_checker (
  input logic                clk,
  input logic                rst_n,
  input pixel_pkg::rgb444_t  pix_in,
  input logic                pix_active,
  input logic                frame_end,
  input pixel_pkg::rgb888_t  pix_out,
  input logic                pix_out_active,
  input steer_pkg::verdict_t verdict,
  input logic                verdict_valid
);

  typedef struct packed {
    int                    num;
    steer_pkg::direction_t dir;
    logic                  det;
  } expect_t;

  expect_t            expected_q [$];
  // winning count of each finished frame, oldest first
  int                 frame_max_q [$];
  int                 zone_cnt [`ZONE_COUNT];
  int                 col;
  logic               have_exp;
  logic               exp_act;
  pixel_pkg::rgb888_t exp_pix;
  int                 pixel_errors = 0;
  int                 other_errors = 0;
  int                 tests_passed = 0;
  int                 tests_failed = 0;
  int                 verdicts_seen = 0;

  task automatic expect_verdict(input int num, input steer_pkg::direction_t dir, input logic det);
    expected_q.push_back('{num: num, dir: dir, det: det});
  endtask

  // window on channels scaled by 17
  function automatic logic orange(input pixel_pkg::rgb444_t p);
    return (p.r * 17 >= `ORANGE_R_MIN) && (p.g * 17 >= `ORANGE_G_MIN) &&
           (p.g * 17 <= `ORANGE_G_MAX) && (p.b * 17 <= `ORANGE_B_MAX);
  endfunction

  function automatic pixel_pkg::rgb888_t shown(input pixel_pkg::rgb444_t p, input logic act);
    pixel_pkg::rgb888_t c;
    c.r = 8'(p.r * 17);
    c.g = 8'(p.g * 17);
    c.b = 8'(p.b * 17);
    if (!act) begin
      c = '0;
    end else if (orange(p)) begin
      c = '1;
    end
    return c;
  endfunction

  task automatic check_pixel();
    if (pix_out_active !== exp_act) begin
      pixel_errors++;
      $display("error %0t: pix_out_active %b, expected %b", $time, pix_out_active, exp_act);
    end
    if (pix_out !== exp_pix) begin
      pixel_errors++;
      $display("error %0t: pix_out %h, expected %h", $time, pix_out, exp_pix);
    end
  endtask

  task automatic track_zones();
    int best;
    if (frame_end) begin
      best = 0;
      foreach (zone_cnt[z]) begin
        if (zone_cnt[z] > best) begin
          best = zone_cnt[z];
        end
        zone_cnt[z] = 0;
      end
      frame_max_q.push_back(best);
      col = 0;
    end else if (pix_active) begin
      if (orange(pix_in)) begin
        zone_cnt[col / `ZONE_WIDTH]++;
      end
      col = (col == `FRAME_WIDTH - 1) ? 0 : col + 1;
    end
  endtask

  task automatic check_verdict();
    expect_t e;
    int      cnt;
    logic    ok;
    verdicts_seen++;
    if (expected_q.size() == 0 || frame_max_q.size() == 0) begin
      other_errors++;
      $display("verdict_valid pulsed at %0t with no frame waiting for a verdict", $time);
    end else begin
      e   = expected_q.pop_front();
      cnt = frame_max_q.pop_front();
      ok  = (verdict.direction === e.dir) && (verdict.detected === e.det) &&
            (verdict.count === cnt);
      if (ok) begin
        tests_passed++;
      end else begin
        tests_failed++;
        $display("error %0t: test %0d got %s/%0b/%0d, expected %s/%0b/%0d", $time, e.num,
                 verdict.direction.name(), verdict.detected, verdict.count,
                 e.dir.name(), e.det, cnt);
      end
      $display("test %0d %s: direction %s, detected %0b, count %0d", e.num,
               ok ? "passed" : "failed", verdict.direction.name(), verdict.detected,
               verdict.count);
    end
  endtask

  // outputs here belong to the inputs of the previous edge
  always @(posedge clk) begin
    if (!rst_n) begin
      have_exp = 1'b0;
      col      = 0;
      foreach (zone_cnt[z]) begin
        zone_cnt[z] = 0;
      end
    end else begin
      if (have_exp) begin
        check_pixel();
      end
      exp_act  = pix_active;
      exp_pix  = shown(pix_in, pix_active);
      have_exp = 1'b1;
      track_zones();
      if (verdict_valid) begin
        check_verdict();
      end
    end
  end

endmodule

/* verif/target_tracker_tb.sv */
// target tracker testbench: reads frame descriptions from the tests file and drives them into the dut
`timescale 1ns/1ps
`include "target_settings.svh"

module target_tracker_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int SEED         = 93296;
  // an idle gap may follow every 32nd pixel of a line
  localparam int GAP_EVERY    = 32;
  localparam int MAX_GAP      = 3;

  // one line of the tests file
  typedef struct packed {
    int                          num;
    int                          lines;
    logic [11:0]                 colour;
    logic [`ZONE_COUNT-1:0][7:0] runs;
    logic [2:0]                  dir;
    logic                        det;
  } test_t;

  logic                clk;
  logic                rst_n;
  pixel_pkg::rgb444_t  pix_in;
  logic                pix_active;
  logic                frame_end;
  pixel_pkg::rgb888_t  pix_out;
  logic                pix_out_active;
  steer_pkg::verdict_t verdict;
  logic                verdict_valid;

  test_t tests [$];
  int    cycle_limit;
  int    cycle_count;
  logic  limit_ready;

  always #(CLK_PERIOD / 2) clk = ~clk;

  target_tracker dut (.*);

  target_tracker_checker u_checker (.*);

  task automatic load_tests(output bit ok);
    int          fd;
    string       line;
    int          fields;
    int          num, lines, r0, r1, r2, r3, r4, dir, det;
    logic [11:0] colour;
    test_t       t;
    ok = 1'b0;
    fd = $fopen("verif/target_tracker_tests.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip comments and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%d %d %h %d %d %d %d %d %d %d",
                           num, lines, colour, r0, r1, r2, r3, r4, dir, det);
          if (fields == 10) begin
            t.num     = num;
            t.lines   = lines;
            t.colour  = colour;
            t.runs[0] = 8'(r0);
            t.runs[1] = 8'(r1);
            t.runs[2] = 8'(r2);
            t.runs[3] = 8'(r3);
            t.runs[4] = 8'(r4);
            t.dir     = 3'(dir);
            t.det     = det[0];
            tests.push_back(t);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // worst case: every gap at its longest, plus the frame_end cycle
  function automatic int frame_cycles();
    int sum;
    sum = 0;
    foreach (tests[i]) begin
      sum += tests[i].lines * (`FRAME_WIDTH + (`FRAME_WIDTH / GAP_EVERY) * MAX_GAP) + 1;
    end
    return sum;
  endfunction

  // blue nibble of 8 or more is always past the blue ceiling
  function automatic logic [11:0] background();
    logic [11:0] c;
    c[11:4] = 8'($urandom);
    c[3:0]  = 4'h8 | 4'($urandom);
    return c;
  endfunction

  task automatic drive_cycle(input logic active, input logic [11:0] colour, input logic fend);
    @(posedge clk);
    pix_active <= active;
    pix_in     <= colour;
    frame_end  <= fend;
  endtask

  // orange run at the left of each band, background after it
  task automatic drive_frame(input test_t t);
    int zone;
    int pos;
    int gap;
    for (int ln = 0; ln < t.lines; ln++) begin
      for (int x = 0; x < `FRAME_WIDTH; x++) begin
        zone = x / `ZONE_WIDTH;
        pos  = x % `ZONE_WIDTH;
        drive_cycle(1'b1, (pos < t.runs[zone]) ? t.colour : background(), 1'b0);
        if (x % GAP_EVERY == GAP_EVERY - 1) begin
          gap = $urandom % (MAX_GAP + 1);
          repeat (gap) drive_cycle(1'b0, background(), 1'b0);
        end
      end
    end
    // next frame starts right after, no idle cycle
    drive_cycle(1'b0, background(), 1'b1);
  endtask

  initial begin
    bit ok;
    clk         = 1'b0;
    rst_n       = 1'b0;
    pix_in      = '0;
    pix_active  = 1'b0;
    frame_end   = 1'b0;
    limit_ready = 1'b0;
    cycle_count = 0;
    void'($urandom(SEED));
    load_tests(ok);
    if (!ok || tests.size() == 0) begin
      $display("the tests file could not be read or holds no tests, nothing was run");
      $display("=== FAIL ===");
      $finish;
    end else begin
      cycle_limit = 2 * frame_cycles() + 100;
      limit_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      foreach (tests[i]) begin
        u_checker.expect_verdict(tests[i].num, steer_pkg::direction_t'(tests[i].dir),
                                 tests[i].det);
        drive_frame(tests[i]);
      end
      drive_cycle(1'b0, '0, 1'b0);
      wait (u_checker.verdicts_seen == tests.size());
      repeat (4) @(posedge clk);
      $display("tests %0d, passed %0d, failed %0d, pixel errors %0d, other %0d, sva %0d",
               tests.size(), u_checker.tests_passed, u_checker.tests_failed,
               u_checker.pixel_errors, u_checker.other_errors, dut.u_sva.fail_count);
      if (u_checker.tests_failed == 0 && u_checker.pixel_errors == 0 &&
          u_checker.other_errors == 0 && dut.u_sva.fail_count == 0 &&
          u_checker.tests_passed == tests.size()) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

  // run limit from the frame lengths in the file
  initial begin
    wait (limit_ready);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run ended before all verdicts arrived", cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verif/target_tracker_tests.txt */
# test lines colour(rgb444) run_z0 run_z1 run_z2 run_z3 run_z4 direction detected
# direction 0 none, 1 hard_left, 2 left, 3 ahead, 4 right, 5 hard_right
1 2 F80 20 0 0 0 0 1 1
2 2 F80 0 20 0 0 0 2 1
3 2 F80 0 0 20 0 0 3 1
4 2 F80 0 0 0 20 0 4 1
5 2 F80 0 0 0 0 20 5 1
6 1 F80 31 0 0 0 0 0 0
7 1 F80 32 0 0 0 0 1 1
8 2 F80 0 0 25 0 25 3 1
9 2 F80 10 30 30 5 0 2 1
10 1 C80 0 40 0 0 0 2 1
11 1 B80 0 40 0 0 0 0 0
12 1 F40 0 0 40 0 0 3 1
13 1 F30 0 0 40 0 0 0 0
14 1 FA0 0 0 0 40 0 4 1
15 1 FB0 0 0 0 40 0 0 0
16 1 F84 0 0 0 0 40 5 1
17 1 F85 0 0 0 0 40 0 0
18 3 F80 64 64 64 64 64 1 1
19 1 F80 0 0 0 0 0 0 0

/* project.f */
+incdir+logic
logic/pixel_pkg.sv
logic/steer_pkg.sv
logic/pixel_classifier.sv
logic/zone_counter.sv
logic/steer_decider.sv
logic/target_tracker.sv
verif/target_tracker_sva.sv
verif/target_tracker_checker.sv
verif/target_tracker_tb.sv

/* Bender.yml */
package:
  name: target_tracker

sources:
  - include_dirs:
      - logic
    files:
      - logic/pixel_pkg.sv
      - logic/steer_pkg.sv
      - logic/pixel_classifier.sv
      - logic/zone_counter.sv
      - logic/steer_decider.sv
      - logic/target_tracker.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/target_tracker_sva.sv
      - verif/target_tracker_checker.sv
      - verif/target_tracker_tb.sv
